// File: hw/scope_macros.svh
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// adc sample width
`define ADC_BITS 5

// visible frame and coordinate widths
`define FB_W 16
`define FB_H 16
`define FB_X_BITS 4
`define FB_Y_BITS 4

// horizontal timing in cycles, 24 per line
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL (`FB_W + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines, 20 per frame
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`FB_H + `V_FRONT + `V_SYNC + `V_BACK)

`define COLOR_BITS 4

// cycles from reset release to the first frame
`define START_DELAY 8

`endif

// File: hw/scope_pkg.sv
`default_nettype none

`include "scope_macros.svh"

package scope_pkg;

  // one 12 bit pixel
  typedef struct packed {
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] grn;
    logic [`COLOR_BITS-1:0] blu;
  } pixel_t;

  // frame buffer write request
  typedef struct packed {
    logic [`FB_X_BITS-1:0] x;
    logic [`FB_Y_BITS-1:0] y;
    pixel_t                color;
  } fb_write_t;

  // video pins, both syncs active low
  typedef struct packed {
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] grn;
    logic [`COLOR_BITS-1:0] blu;
    logic                   hsync;
    logic                   vsync;
  } vga_out_t;

endpackage

`default_nettype wire

// File: hw/plot_source.sv
`default_nettype none

`include "scope_macros.svh"

module plot_source
  import scope_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`ADC_BITS-1:0] adc_x,
  input  logic [`ADC_BITS-1:0] adc_y,
  output fb_write_t            wr,
  output logic                 wr_valid,
  input  logic                 wr_ready
);

  localparam int POS_BITS = `FB_Y_BITS + `FB_X_BITS;

  logic [POS_BITS-1:0]   clr_pos;
  logic                  clr_done;
  logic [`FB_X_BITS-1:0] pt_x;
  logic [`FB_Y_BITS-1:0] pt_y;
  logic                  xfer;

  // the sweep starts at once and plotting never pauses
  assign wr_valid = 1'b1;
  assign xfer     = wr_valid && wr_ready;

  // raster-order clear sweep, advances only on accepted writes
  always_ff @(posedge clk) begin
    if (reset) begin
      clr_pos  <= '0;
      clr_done <= 1'b0;
    end else if (xfer && !clr_done) begin
      clr_pos <= clr_pos + 1'b1;
      if (clr_pos == '1) begin
        clr_done <= 1'b1;
      end
    end
  end

  // halved sample point, held while the buffer stalls us
  always_ff @(posedge clk) begin
    if (wr_ready) begin
      pt_x <= adc_x[`ADC_BITS-1:1];
      pt_y <= adc_y[`ADC_BITS-1:1];
    end
  end

  always_comb begin
    if (clr_done) begin
      wr.x         = pt_x;
      wr.y         = pt_y;
      wr.color.red = '1;
      wr.color.grn = '1;
      wr.color.blu = '1;
    end else begin
      // black at the sweep position
      wr.x         = clr_pos[`FB_X_BITS-1:0];
      wr.y         = clr_pos[POS_BITS-1:`FB_X_BITS];
      wr.color.red = '0;
      wr.color.grn = '0;
      wr.color.blu = '0;
    end
  end

  // a stalled request must not change under the consumer
  a_wr_stable : assert property (
    @(posedge clk) disable iff (reset)
    (wr_valid && !wr_ready) |=> $stable(wr)
  );

endmodule

`default_nettype wire

// File: hw/frame_buffer.sv
`default_nettype none

`include "scope_macros.svh"

module frame_buffer
  import scope_pkg::*;
(
  input  logic                                 clk,
  input  fb_write_t                            wr,
  input  logic                                 wr_valid,
  output logic                                 wr_ready,
  input  logic                                 blanking,
  input  logic                                 rd_en,
  input  logic [`FB_Y_BITS+`FB_X_BITS-1:0]     rd_addr,
  output pixel_t                               rd_data
);

  localparam int DEPTH = `FB_W * `FB_H;

  pixel_t                               mem [DEPTH];
  logic [`FB_Y_BITS+`FB_X_BITS-1:0]     wr_addr;
  logic                                 wr_en;

  // the port belongs to scanout during the visible area
  assign wr_ready = blanking;
  assign wr_en    = wr_valid && wr_ready;

  // row-major layout, same as the scanout address
  assign wr_addr = {wr.y, wr.x};

  // one port, so a cycle either writes or reads
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr.color;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // scanout timing must keep reads out of the write window
  a_port_conflict : assert property (
    @(posedge clk)
    !(rd_en && wr_en)
  );

endmodule

`default_nettype wire

// File: hw/vga_scanout.sv
`default_nettype none

`include "scope_macros.svh"

module vga_scanout
  import scope_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset,
  output logic                             rd_en,
  output logic [`FB_Y_BITS+`FB_X_BITS-1:0] rd_addr,
  input  pixel_t                           rd_data,
  output logic                             blanking,
  output vga_out_t                         vga
);

  localparam int H_W   = $clog2(`H_TOTAL);
  localparam int V_W   = $clog2(`V_TOTAL);
  localparam int DLY_W = $clog2(`START_DELAY + 1);

  localparam logic [H_W-1:0]   H_LAST   = H_W'(`H_TOTAL - 1);
  localparam logic [V_W-1:0]   V_LAST   = V_W'(`V_TOTAL - 1);
  localparam logic [H_W-1:0]   H_VIS    = H_W'(`FB_W);
  localparam logic [V_W-1:0]   V_VIS    = V_W'(`FB_H);
  localparam logic [H_W-1:0]   HS_START = H_W'(`FB_W + `H_FRONT);
  localparam logic [H_W-1:0]   HS_END   = H_W'(`FB_W + `H_FRONT + `H_SYNC);
  localparam logic [V_W-1:0]   VS_START = V_W'(`FB_H + `V_FRONT);
  localparam logic [V_W-1:0]   VS_END   = V_W'(`FB_H + `V_FRONT + `V_SYNC);
  localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(`START_DELAY - 1);

  logic [DLY_W-1:0] delay_cnt;
  logic             running;
  logic [H_W-1:0]   h_cnt;
  logic [V_W-1:0]   v_cnt;
  logic             visible;
  logic             hsync_win;
  logic             vsync_win;
  logic             visible_q;
  logic             hsync_q;
  logic             vsync_q;

  // hold off scanout so the plot side gets going first
  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt <= '0;
      running   <= 1'b0;
    end else if (!running) begin
      if (delay_cnt == DLY_LAST) begin
        running <= 1'b1;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (running) begin
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign visible   = running && (h_cnt < H_VIS) && (v_cnt < V_VIS);
  assign hsync_win = running && (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vsync_win = running && (v_cnt >= VS_START) && (v_cnt < VS_END);

  assign rd_en    = visible;
  assign rd_addr  = {v_cnt[`FB_Y_BITS-1:0], h_cnt[`FB_X_BITS-1:0]};
  // idle scanout does not open the write window
  assign blanking = running && !visible;

  // delay sync and the visible flag to line up with read data
  always_ff @(posedge clk) begin
    if (reset) begin
      visible_q <= 1'b0;
      hsync_q   <= 1'b1;
      vsync_q   <= 1'b1;
    end else begin
      visible_q <= visible;
      hsync_q   <= !hsync_win;
      vsync_q   <= !vsync_win;
    end
  end

  always_comb begin
    vga.red   = visible_q ? rd_data.red : '0;
    vga.grn   = visible_q ? rd_data.grn : '0;
    vga.blu   = visible_q ? rd_data.blu : '0;
    vga.hsync = hsync_q;
    vga.vsync = vsync_q;
  end

  // a pulse ends at the window edge after exactly the sync width
  a_hsync_window : assert property (
    @(posedge clk) disable iff (reset)
    $rose(vga.hsync) |-> ($past(h_cnt) == HS_END) && !$past(vga.hsync, `H_SYNC)
                         && $past(vga.hsync, `H_SYNC + 1)
  );

endmodule

`default_nettype wire

// File: hw/scope_top.sv
`default_nettype none

`include "scope_macros.svh"

module scope_top
  import scope_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`ADC_BITS-1:0] adc_x,
  input  logic [`ADC_BITS-1:0] adc_y,
  output vga_out_t             vga
);

  // write path
  fb_write_t wr;
  logic      wr_valid;
  logic      wr_ready;

  // read path
  logic                             rd_en;
  logic [`FB_Y_BITS+`FB_X_BITS-1:0] rd_addr;
  pixel_t                           rd_data;
  logic                             blanking;

  plot_source u_plot (
    .clk      (clk),
    .reset    (reset),
    .adc_x    (adc_x),
    .adc_y    (adc_y),
    .wr       (wr),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready)
  );

  frame_buffer u_fb (
    .clk      (clk),
    .wr       (wr),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .blanking (blanking),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  vga_scanout u_scan (
    .clk      (clk),
    .reset    (reset),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .blanking (blanking),
    .vga      (vga)
  );

endmodule

`default_nettype wire

// File: bench/scope_checker.sv
`default_nettype none

`include "scope_macros.svh"

module scope_checker
  import scope_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`ADC_BITS-1:0] adc_x,
  input  logic [`ADC_BITS-1:0] adc_y,
  input  vga_out_t             vga,
  input  logic                 finish,
  output logic                 done,
  output int                   errors
);

  timeunit 1ns;
  timeprecision 1ps;

  // first line of the vsync pulse
  localparam int VS_FIRST = `FB_H + `V_FRONT;

  bit                   shadow [`FB_W * `FB_H];
  logic [`ADC_BITS-1:0] cur_x;
  logic [`ADC_BITS-1:0] cur_y;
  bit                   have_sample;
  bit                   locked;
  bit                   vs_prev = 1'b1;
  int                   sample_idx = -1;
  int                   settle;
  int                   frames;
  int                   errs_open;
  int                   h;
  int                   v;
  int                   hs_low;
  int                   vs_low;
  int                   passed;
  int                   failed;

  task automatic check_color(input string name, input logic [`COLOR_BITS-1:0] got,
                             input logic [`COLOR_BITS-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s at (%0d,%0d): expected %0h, got %0h", name, h, v, exp, got);
    end
  endtask

  task automatic close_sample();
    if (frames == 0) begin
      errors++;
      $display("sample %0d was held too briefly to be compared", sample_idx);
    end
    if (errors == errs_open) passed++;
    else failed++;
    $display("sample %0d adc (%0d,%0d) pixel (%0d,%0d): %0d frames compared, %s",
             sample_idx, cur_x, cur_y, cur_x >> 1, cur_y >> 1, frames,
             (errors == errs_open) ? "ok" : "failed");
  endtask

  task automatic open_sample();
    if (have_sample) close_sample();
    have_sample = 1'b1;
    sample_idx++;
    cur_x = adc_x;
    cur_y = adc_y;
    // plotted points are never erased
    shadow[(adc_y >> 1) * `FB_W + (adc_x >> 1)] = 1'b1;
    settle    = 0;
    frames    = 0;
    errs_open = errors;
  endtask

  task automatic check_cycle();
    logic [`COLOR_BITS-1:0] exp;
    bit                     vis;
    vis = (h < `FB_W) && (v < `FB_H);
    exp = '0;
    // visible pixels only once two blanking periods have passed
    if (!vis || settle >= 2) begin
      if (vis && shadow[v * `FB_W + h]) exp = '1;
      check_color("red", vga.red, exp);
      check_color("grn", vga.grn, exp);
      check_color("blu", vga.blu, exp);
      if (vis && h == `FB_W - 1 && v == `FB_H - 1) frames++;
    end
    if (!vga.hsync) hs_low++;
    if (!vga.vsync) vs_low++;
    if (h == `H_TOTAL - 1) begin
      if (hs_low != `H_SYNC) begin
        errors++;
        $display("Mismatch hsync low cycles in line %0d: expected %0h, got %0h",
                 v, `H_SYNC, hs_low);
      end
      hs_low = 0;
      // frame window runs from one vsync fall to the next
      if (v == VS_FIRST - 1) begin
        if (vs_low != `V_SYNC * `H_TOTAL) begin
          errors++;
          $display("Mismatch vsync low cycles per frame: expected %0h, got %0h",
                   `V_SYNC * `H_TOTAL, vs_low);
        end
        vs_low = 0;
      end
    end
  endtask

  // sample at the falling edge, away from the DUT's updates
  always @(negedge clk) begin
    if (reset) begin
      done   = 1'b0;
      errors = 0;
    end else if (!done) begin
      if (finish) begin
        close_sample();
        $display("%0d samples checked, %0d ok, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        done = 1'b1;
      end else begin
        if (!have_sample || adc_x != cur_x || adc_y != cur_y) open_sample();
        if (locked) begin
          h++;
          if (h == `H_TOTAL) begin
            h = 0;
            v = (v == `V_TOTAL - 1) ? 0 : v + 1;
          end
        end else if (vs_prev && !vga.vsync) begin
          locked = 1'b1;
          h      = 0;
          v      = VS_FIRST;
        end
        if (vs_prev && !vga.vsync) settle++;
        vs_prev = vga.vsync;
        if (locked) check_cycle();
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/scope_tb.sv
`default_nettype none

`include "scope_macros.svh"

module scope_tb
  import scope_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int AW = `ADC_BITS;
  localparam longint FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

  logic                 clk;
  logic                 reset;
  logic [`ADC_BITS-1:0] adc_x;
  logic [`ADC_BITS-1:0] adc_y;
  logic                 finish;
  logic                 done;
  int                   errors;
  vga_out_t             vga;
  int                   sx[$];
  int                   sy[$];
  int                   sh[$];
  bit                   loaded;
  longint               hold_sum;

  scope_top u_dut (.clk(clk), .reset(reset), .adc_x(adc_x), .adc_y(adc_y), .vga(vga));

  scope_checker u_chk (
    .clk(clk), .reset(reset), .adc_x(adc_x), .adc_y(adc_y), .vga(vga),
    .finish(finish), .done(done), .errors(errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic load_samples();
    int    fd;
    int    x;
    int    y;
    int    hold;
    string line;
    fd = $fopen("bench/adc_input.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.getc(0) != "#" && $sscanf(line, "%d %d %d", x, y, hold) == 3) begin
          sx.push_back(x);
          sy.push_back(y);
          // shorter holds would not leave a settled frame to compare
          sh.push_back((hold < 3) ? 3 : hold);
          hold_sum += sh[$];
        end
      end
      $fclose(fd);
    end
  endtask

  // returns on the rising edge right after vsync has gone low
  task automatic wait_vsync_fall();
    bit was_high;
    bit seen;
    was_high = 1'b0;
    seen     = 1'b0;
    while (!seen) begin
      @(posedge clk);
      seen     = was_high && !vga.vsync;
      was_high = vga.vsync;
    end
  endtask

  // watchdog, twice the expected run plus some slack
  initial begin
    wait (loaded);
    #((2 * hold_sum + 4) * FRAME_CYCLES * 20);
    $display("run timed out before the checker finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    reset  = 1'b1;
    adc_x  = '0;
    adc_y  = '0;
    finish = 1'b0;
    load_samples();
    if (sx.size() == 0) begin
      $display("no samples could be read from bench/adc_input.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      loaded = 1'b1;
      @(posedge clk);
      adc_x <= AW'(sx[0]);
      adc_y <= AW'(sy[0]);
      repeat (7) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < sx.size(); i++) begin
        if (i > 0) begin
          adc_x <= AW'(sx[i]);
          adc_y <= AW'(sy[i]);
        end
        repeat (sh[i]) wait_vsync_fall();
      end
      finish <= 1'b1;
      while (!done) @(posedge clk);
      if (errors == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/scope_pkg.sv
hw/plot_source.sv
hw/frame_buffer.sv
hw/vga_scanout.sv
hw/scope_top.sv
bench/scope_checker.sv
bench/scope_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module scope_tb -f project.f -Mdir obj_dir -o scope_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/scope_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "=== PASS ===" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

// File: bench/adc_input.txt
# adc_x adc_y hold_frames, all decimal
# a sample is held for hold_frames vsync periods, at least 3
10 12 4
0 0 3
31 0 3
0 31 3
31 31 3
20 7 3
21 6 3
3 25 3
16 17 3
9 30 4
27 14 3
5 19 3
31 16 3
12 2 3
